// File: design/drbg_pkg.sv
// Shared types and mixer constants for the reduced-width DRBG front end
// Mixer constants are 32 bits wide and are resized to reg_size where used

package drbg_pkg;

    // ----------------------------------------
    // FSM state encodings
    // ----------------------------------------
    typedef enum logic [2:0] {
        iface_idle,
        iface_lambda,
        iface_scalar_rnd,
        iface_masking_rnd,
        iface_keygen,
        iface_sign,
        iface_done
    } iface_state_e;

    typedef enum logic [2:0] {
        drbg_idle,
        drbg_update_key,
        drbg_update_val,
        drbg_generate,
        drbg_reduce
    } drbg_state_e;

    // Command latched by the DRBG when it leaves idle
    typedef enum logic {
        cmd_init,
        cmd_next
    } drbg_cmd_e;

    // ----------------------------------------
    // Mixer constants
    // ----------------------------------------
    localparam int          mix_rounds = 8;
    localparam int          mix_rot    = 7;
    localparam logic [31:0] mix_const  = 32'h9e37_79b9;

endpackage

// File: design/drbg_mixer.sv
// Iterative keyed mixer, one round per clock; a size stand-in, not cryptographic
// Round 0 runs on the start edge, so done follows start by mix_rounds cycles
// Needs reg_size > mix_rot; a start while a pass is running is ignored

`timescale 1ns/100ps

module drbg_mixer
    import drbg_pkg::*;
#(
    parameter int reg_size = 32
) (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                start,
    input  logic [reg_size-1:0] key,
    input  logic [reg_size-1:0] data_in,
    output logic [reg_size-1:0] data_out,
    output logic                done
);

    localparam int cnt_w = $clog2(mix_rounds);

    logic [reg_size-1:0] key_reg;
    logic [reg_size-1:0] state_reg;
    logic [cnt_w-1:0]    round_cnt;
    logic                busy;

    // XOR key, rotate left, add the round constant scaled by r+1
    function automatic logic [reg_size-1:0] mix_round(
        input logic [reg_size-1:0] k,
        input logic [reg_size-1:0] x,
        input logic [cnt_w-1:0]    r
    );
        logic [reg_size-1:0] t;
        t = x ^ k;
        t = (t << mix_rot) | (t >> (reg_size - mix_rot));
        return t + reg_size'(mix_const) * (reg_size'(r) + 1'b1);
    endfunction

    // Round counter and done pulse
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            busy      <= 1'b0;
            round_cnt <= '0;
            done      <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start && !busy) begin
                busy      <= 1'b1;
                round_cnt <= cnt_w'(1);
            end else if (busy) begin
                if (round_cnt == cnt_w'(mix_rounds - 1)) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end else begin
                    round_cnt <= round_cnt + 1'b1;
                end
            end
        end
    end

    // Datapath; final round lands on the same edge as done
    always_ff @(posedge clk) begin
        if (start && !busy) begin
            key_reg   <= key;
            state_reg <= mix_round(key, data_in, '0);
        end else if (busy) begin
            state_reg <= mix_round(key_reg, state_reg, round_cnt);
        end
    end

    assign data_out = state_reg;

endmodule

// File: design/hmac_drbg.sv
// HMAC-DRBG style generator on top of drbg_mixer, three mixer passes per command
// group_order must exceed half the word range so one subtraction reduces
// Commands are accepted only while ready is high; init wins over next

`timescale 1ns/100ps

module hmac_drbg
    import drbg_pkg::*;
#(
    parameter int                  reg_size    = 32,
    parameter logic [reg_size-1:0] group_order = 32'hffff_fffb
) (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                mode,
    input  logic                init_cmd,
    input  logic                next_cmd,
    input  logic [reg_size-1:0] seed,
    input  logic [reg_size-1:0] priv_key,
    input  logic [reg_size-1:0] hashed_msg,
    output logic                ready,
    output logic                valid,
    output logic [reg_size-1:0] rnd_out
);

    // Alternating 0101 pattern, low bits kept for any width
    localparam logic [reg_size-1:0] init_v = reg_size'({((reg_size + 1) / 2){2'b01}});

    drbg_state_e         state;
    drbg_cmd_e           cmd;
    logic [reg_size-1:0] k_reg;
    logic [reg_size-1:0] v_reg;
    logic [reg_size-1:0] in_word;

    logic                mix_start;
    logic [reg_size-1:0] mix_data;
    logic [reg_size-1:0] mix_out;
    logic                mix_done;

    drbg_mixer #(
        .reg_size (reg_size)
    ) drbg_mixer_i (
        .clk      (clk),
        .reset_n  (reset_n),
        .start    (mix_start),
        .key      (k_reg),
        .data_in  (mix_data),
        .data_out (mix_out),
        .done     (mix_done)
    );

    // Key update mixes V with the seed word on init, with 1 on next
    always_comb begin
        mix_data = v_reg;
        if (state == drbg_update_key) begin
            mix_data = v_reg ^ ((cmd == cmd_init) ? in_word : reg_size'(1));
        end
    end

    // ----------------------------------------
    // Command sequencing
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state     <= drbg_idle;
            cmd       <= cmd_init;
            mix_start <= 1'b0;
            ready     <= 1'b1;
            valid     <= 1'b0;
            k_reg     <= '0;
            v_reg     <= init_v;
        end else begin
            mix_start <= 1'b0;
            case (state)
                drbg_idle: begin
                    if (init_cmd || next_cmd) begin
                        cmd       <= init_cmd ? cmd_init : cmd_next;
                        ready     <= 1'b0;
                        valid     <= 1'b0;
                        mix_start <= 1'b1;
                        state     <= drbg_update_key;
                        // Init starts again from the fixed K and V
                        if (init_cmd) begin
                            k_reg <= '0;
                            v_reg <= init_v;
                        end
                    end
                end
                drbg_update_key: begin
                    if (mix_done) begin
                        k_reg     <= mix_out;
                        mix_start <= 1'b1;
                        state     <= drbg_update_val;
                    end
                end
                drbg_update_val: begin
                    if (mix_done) begin
                        v_reg     <= mix_out;
                        mix_start <= 1'b1;
                        state     <= drbg_generate;
                    end
                end
                drbg_generate: begin
                    if (mix_done) begin
                        v_reg <= mix_out;
                        state <= drbg_reduce;
                    end
                end
                drbg_reduce: begin
                    ready <= 1'b1;
                    valid <= 1'b1;
                    state <= drbg_idle;
                end
                default: state <= drbg_idle;
            endcase
        end
    end

    // Seed word captured with the command, output reduced once below the order
    always_ff @(posedge clk) begin
        if (state == drbg_idle && (init_cmd || next_cmd)) begin
            in_word <= mode ? (priv_key ^ hashed_msg) : seed;
        end
        if (state == drbg_reduce) begin
            rnd_out <= (v_reg >= group_order) ? v_reg - group_order : v_reg;
        end
    end

endmodule

// File: design/ecc_hmac_drbg_interface.sv
// Sequences the DRBG for lambda, scalar, masking and nonce values
// en is a one-cycle strobe and is ignored while ready is low
// Outputs not produced in a run keep their previous value

`timescale 1ns/100ps

module ecc_hmac_drbg_interface
    import drbg_pkg::*;
#(
    parameter int                  reg_size    = 32,
    parameter logic [reg_size-1:0] group_order = 32'hffff_fffb
) (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                keygen_sign,
    input  logic                en,
    input  logic [reg_size-1:0] seed,
    input  logic [reg_size-1:0] priv_key,
    input  logic [reg_size-1:0] iv,
    input  logic [reg_size-1:0] hashed_msg,
    output logic                ready,
    output logic [reg_size-1:0] lambda,
    output logic [reg_size-1:0] scalar_rnd,
    output logic [reg_size-1:0] masking_rnd,
    output logic [reg_size-1:0] nonce
);

    iface_state_e        state;
    iface_state_e        state_next;
    iface_state_e        state_last;

    logic                hmac_mode;
    logic                hmac_init;
    logic                hmac_next;
    logic                hmac_ready;
    logic                hmac_valid;
    logic                hmac_valid_last;
    logic                hmac_valid_edge;
    logic [reg_size-1:0] hmac_seed;
    logic [reg_size-1:0] hmac_rnd;
    logic                first_cycle;

    hmac_drbg #(
        .reg_size    (reg_size),
        .group_order (group_order)
    ) hmac_drbg_i (
        .clk        (clk),
        .reset_n    (reset_n),
        .mode       (hmac_mode),
        .init_cmd   (hmac_init),
        .next_cmd   (hmac_next),
        .seed       (hmac_seed),
        .priv_key   (priv_key),
        .hashed_msg (hashed_msg),
        .ready      (hmac_ready),
        .valid      (hmac_valid),
        .rnd_out    (hmac_rnd)
    );

    assign first_cycle     = (state != state_last);
    assign hmac_valid_edge = hmac_valid && !hmac_valid_last;
    assign ready           = (state == iface_idle);

    // ----------------------------------------
    // DRBG request per state
    // ----------------------------------------
    always_comb begin
        hmac_mode = (state == iface_sign);
        hmac_seed = '0;
        hmac_init = 1'b0;
        hmac_next = 1'b0;
        case (state)
            iface_lambda, iface_scalar_rnd, iface_masking_rnd: hmac_seed = iv;
            iface_keygen: hmac_seed = seed;
            default:      hmac_seed = '0;
        endcase
        // Command on the first cycle only; the DRBG is ready there
        if (first_cycle && hmac_ready) begin
            case (state)
                iface_lambda, iface_keygen, iface_sign: hmac_init = 1'b1;
                iface_scalar_rnd, iface_masking_rnd:    hmac_next = 1'b1;
                default: ;
            endcase
        end
    end

    // Next state
    always_comb begin
        state_next = state;
        case (state)
            iface_idle: begin
                if (en && hmac_ready) state_next = iface_lambda;
            end
            iface_lambda: begin
                if (hmac_valid_edge) state_next = iface_scalar_rnd;
            end
            iface_scalar_rnd: begin
                if (hmac_valid_edge) begin
                    state_next = keygen_sign ? iface_masking_rnd : iface_keygen;
                end
            end
            iface_masking_rnd: begin
                if (hmac_valid_edge) state_next = iface_sign;
            end
            iface_keygen, iface_sign: begin
                if (hmac_valid_edge) state_next = iface_done;
            end
            default: state_next = iface_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state           <= iface_idle;
            state_last      <= iface_idle;
            hmac_valid_last <= 1'b0;
        end else begin
            state           <= state_next;
            state_last      <= state;
            hmac_valid_last <= hmac_valid;
        end
    end

    // Result capture on the valid edge
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            lambda      <= '0;
            scalar_rnd  <= '0;
            masking_rnd <= '0;
            nonce       <= '0;
        end else if (hmac_valid_edge) begin
            case (state)
                iface_lambda:             lambda      <= hmac_rnd;
                iface_scalar_rnd:         scalar_rnd  <= hmac_rnd;
                iface_masking_rnd:        masking_rnd <= hmac_rnd;
                iface_keygen, iface_sign: nonce       <= hmac_rnd;
                default: ;
            endcase
        end
    end

endmodule

// File: design/ecc_drbg_top.sv
// Top level of the random-value front end; sets width and group order
// group_order must exceed half the word range

`timescale 1ns/100ps

module ecc_drbg_top #(
    parameter int                  reg_size    = 32,
    parameter logic [reg_size-1:0] group_order = 32'hffff_fffb
) (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                keygen_sign,
    input  logic                en,
    input  logic [reg_size-1:0] seed,
    input  logic [reg_size-1:0] priv_key,
    input  logic [reg_size-1:0] iv,
    input  logic [reg_size-1:0] hashed_msg,
    output logic                ready,
    output logic [reg_size-1:0] lambda,
    output logic [reg_size-1:0] scalar_rnd,
    output logic [reg_size-1:0] masking_rnd,
    output logic [reg_size-1:0] nonce
);

    ecc_hmac_drbg_interface #(
        .reg_size    (reg_size),
        .group_order (group_order)
    ) ecc_hmac_drbg_interface_i (
        .clk         (clk),
        .reset_n     (reset_n),
        .keygen_sign (keygen_sign),
        .en          (en),
        .seed        (seed),
        .priv_key    (priv_key),
        .iv          (iv),
        .hashed_msg  (hashed_msg),
        .ready       (ready),
        .lambda      (lambda),
        .scalar_rnd  (scalar_rnd),
        .masking_rnd (masking_rnd),
        .nonce       (nonce)
    );

endmodule

// File: testbench/drbg_model.svh
// Reference model of mixer, DRBG and request sequence for 32-bit words only
// Included inside the testbench module; takes the mixer constants from drbg_pkg

// Galois LFSR step, x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0]) begin
        n = n ^ 32'h8020_0003;
    end
    return n;
endfunction

// Eight rounds of XOR key, rotate left, add scaled constant
function automatic logic [31:0] mix_model(input logic [31:0] k, input logic [31:0] d);
    logic [31:0] x;
    x = d;
    for (int r = 0; r < drbg_pkg::mix_rounds; r++) begin
        x = x ^ k;
        x = (x << drbg_pkg::mix_rot) | (x >> (32 - drbg_pkg::mix_rot));
        x = x + drbg_pkg::mix_const * 32'(r + 1);
    end
    return x;
endfunction

// One command, raw V before reduction
function automatic void drbg_step(input bit is_init, input logic [31:0] in_word,
                                  inout logic [31:0] k, inout logic [31:0] v,
                                  output logic [31:0] raw);
    if (is_init) begin
        k = '0;
        v = 32'h5555_5555;
        k = mix_model(k, v ^ in_word);
    end else begin
        k = mix_model(k, v ^ 32'd1);
    end
    v   = mix_model(k, v);
    v   = mix_model(k, v);
    raw = v;
endfunction

function automatic logic [31:0] reduce_model(input logic [31:0] raw, input logic [31:0] order);
    return (raw >= order) ? raw - order : raw;
endfunction

// Whole run; mask is only written on signing
function automatic void sequence_model(input bit sign, input logic [31:0] seed_w,
                                       input logic [31:0] priv_w, input logic [31:0] iv_w,
                                       input logic [31:0] hash_w, input logic [31:0] order,
                                       output logic [31:0] lam, output logic [31:0] scal,
                                       inout logic [31:0] mask, output logic [31:0] non);
    logic [31:0] k;
    logic [31:0] v;
    logic [31:0] raw;
    k = '0;
    v = '0;
    drbg_step(1'b1, iv_w, k, v, raw);
    lam = reduce_model(raw, order);
    drbg_step(1'b0, '0, k, v, raw);
    scal = reduce_model(raw, order);
    if (sign) begin
        drbg_step(1'b0, '0, k, v, raw);
        mask = reduce_model(raw, order);
        drbg_step(1'b1, priv_w ^ hash_w, k, v, raw);
    end else begin
        drbg_step(1'b1, seed_w, k, v, raw);
    end
    non = reduce_model(raw, order);
endfunction

// File: testbench/ecc_drbg_tb.sv
// Table of key-generation and signing runs checked against the reference model
// Uses a reduced group order so that the output subtraction is reachable

`timescale 1ns/100ps

module ecc_drbg_tb;

    localparam int          reg_size    = 32;
    // Low enough that a raw V above it turns up in a short search
    localparam logic [31:0] group_order = 32'hf000_000b;
    localparam int          num_tests   = 8;
    localparam int          run_timeout = 2000;
    localparam int          search_max  = 4096;

    logic        clk;
    logic        reset_n;
    logic        keygen_sign;
    logic        en;
    logic [31:0] seed;
    logic [31:0] priv_key;
    logic [31:0] iv;
    logic [31:0] hashed_msg;
    logic        ready;
    logic [31:0] lambda;
    logic [31:0] scalar_rnd;
    logic [31:0] masking_rnd;
    logic [31:0] nonce;

    // ----------------------------------------
    // Stimulus and expected values
    // ----------------------------------------
    string       t_name    [num_tests];
    logic        t_sign    [num_tests];
    logic        t_busy_en [num_tests];
    logic        t_repeat  [num_tests];
    logic [31:0] t_seed    [num_tests];
    logic [31:0] t_priv    [num_tests];
    logic [31:0] t_iv      [num_tests];
    logic [31:0] t_hash    [num_tests];
    logic [31:0] x_lambda  [num_tests];
    logic [31:0] x_scalar  [num_tests];
    logic [31:0] x_mask    [num_tests];
    logic [31:0] x_nonce   [num_tests];

    logic [31:0] lfsr_state;
    int          errors;
    int          checks;
    bit          timed_out;

    `include "drbg_model.svh"

    ecc_drbg_top #(
        .reg_size    (reg_size),
        .group_order (group_order)
    ) ecc_drbg_top_i (
        .clk         (clk),
        .reset_n     (reset_n),
        .keygen_sign (keygen_sign),
        .en          (en),
        .seed        (seed),
        .priv_key    (priv_key),
        .iv          (iv),
        .hashed_msg  (hashed_msg),
        .ready       (ready),
        .lambda      (lambda),
        .scalar_rnd  (scalar_rnd),
        .masking_rnd (masking_rnd),
        .nonce       (nonce)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // One LFSR step per bit taken
    function automatic logic [31:0] rand_word();
        logic [31:0] w;
        w = '0;
        for (int b = 0; b < 32; b++) begin
            w          = {w[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return w;
    endfunction

    task automatic set_entry(input int i, input string name, input logic sign,
                             input logic [31:0] s, input logic [31:0] p,
                             input logic [31:0] v, input logic [31:0] h);
        t_name[i] = name;
        t_sign[i] = sign;
        t_seed[i] = s;
        t_priv[i] = p;
        t_iv[i]   = v;
        t_hash[i] = h;
    endtask

    task automatic check_word(input string test, input string field,
                              input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAIL %s %s expected %h actual %h", test, field, exp, act);
        end
    endtask

    task automatic check_below_order(input string test, input string field,
                                     input logic [31:0] act);
        checks++;
        if (act >= group_order) begin
            errors++;
            $display("FAIL %s %s expected below %h actual %h", test, field, group_order, act);
        end
    endtask

    task automatic build_table();
        logic [31:0] k;
        logic [31:0] v;
        logic [31:0] raw;
        logic [31:0] cand;
        logic [31:0] mask;
        bit          found;
        for (int i = 0; i < num_tests; i++) begin
            t_busy_en[i] = 1'b0;
            t_repeat[i]  = 1'b0;
        end
        set_entry(0, "keygen_fixed", 1'b0, 32'h0123_4567, 32'h0, 32'h89ab_cdef, 32'h0);
        set_entry(1, "sign_fixed", 1'b1, 32'h0, 32'h1357_9bdf, 32'h2468_ace0, 32'hdead_beef);
        set_entry(2, "keygen_reduce", 1'b0, 32'h0f0f_0f0f, 32'h0, 32'h0, 32'h0);
        set_entry(3, "sign_busy_en", 1'b1, 32'h0, 32'hcafe_f00d, 32'h7777_0001, 32'h1234_5678);
        t_busy_en[3] = 1'b1;
        // Search for an iv whose raw lambda needs the subtraction
        found = 1'b0;
        for (int n = 0; n < search_max && !found; n++) begin
            cand = 32'h3c3c_0000 + 32'(n);
            drbg_step(1'b1, cand, k, v, raw);
            if (raw >= group_order) begin
                found   = 1'b1;
                t_iv[2] = cand;
            end
        end
        checks++;
        if (!found) begin
            errors++;
            $display("No iv found that drives the raw lambda above the group order");
        end
        for (int i = 4; i < 7; i++) begin
            case (i)
                4:       t_name[i] = "keygen_rand";
                5:       t_name[i] = "sign_rand";
                default: t_name[i] = "sign_rand_b";
            endcase
            t_sign[i] = (i != 4);
            t_seed[i] = rand_word();
            t_priv[i] = rand_word();
            t_iv[i]   = rand_word();
            t_hash[i] = rand_word();
        end
        set_entry(7, "sign_repeat", t_sign[6], t_seed[6], t_priv[6], t_iv[6], t_hash[6]);
        t_repeat[7] = 1'b1;
        mask = '0;
        for (int i = 0; i < num_tests; i++) begin
            sequence_model(t_sign[i], t_seed[i], t_priv[i], t_iv[i], t_hash[i], group_order,
                           x_lambda[i], x_scalar[i], mask, x_nonce[i]);
            x_mask[i] = mask;
        end
    endtask

    task automatic wait_ready(input string test);
        int cnt;
        cnt = 0;
        while (!ready && cnt < run_timeout) begin
            @(negedge clk);
            cnt++;
        end
        if (!ready) begin
            errors++;
            timed_out = 1'b1;
            $display("%s: timed out waiting for ready to return high", test);
        end
    endtask

    // ----------------------------------------
    // One table entry
    // ----------------------------------------
    task automatic run_entry(input int i);
        logic [31:0] prev_lambda;
        logic [31:0] prev_nonce;
        int          hold;
        prev_lambda = lambda;
        prev_nonce  = nonce;
        @(negedge clk);
        keygen_sign = t_sign[i];
        seed        = t_seed[i];
        priv_key    = t_priv[i];
        iv          = t_iv[i];
        hashed_msg  = t_hash[i];
        en          = 1'b1;
        @(negedge clk);
        en = 1'b0;
        checks++;
        if (ready) begin
            errors++;
            $display("%s: ready stayed high after the en strobe", t_name[i]);
        end
        if (t_busy_en[i]) begin
            // Second strobe lands in the middle of the run
            // A restarted run would take its lambda from the inverted iv
            repeat (5) @(negedge clk);
            iv = ~t_iv[i];
            en = 1'b1;
            @(negedge clk);
            en = 1'b0;
        end
        wait_ready(t_name[i]);
        if (!timed_out) begin
            if (t_busy_en[i]) begin
                hold = 0;
                while (ready && hold < 100) begin
                    @(negedge clk);
                    hold++;
                end
                checks++;
                if (!ready) begin
                    errors++;
                    $display("%s: a second run started from an en strobe while busy", t_name[i]);
                end
            end
            check_word(t_name[i], "lambda", x_lambda[i], lambda);
            check_word(t_name[i], "scalar_rnd", x_scalar[i], scalar_rnd);
            check_word(t_name[i], "masking_rnd", x_mask[i], masking_rnd);
            check_word(t_name[i], "nonce", x_nonce[i], nonce);
            check_below_order(t_name[i], "lambda", lambda);
            check_below_order(t_name[i], "scalar_rnd", scalar_rnd);
            check_below_order(t_name[i], "masking_rnd", masking_rnd);
            check_below_order(t_name[i], "nonce", nonce);
            if (t_repeat[i]) begin
                check_word(t_name[i], "lambda_vs_previous", prev_lambda, lambda);
                check_word(t_name[i], "nonce_vs_previous", prev_nonce, nonce);
            end
        end
    endtask

    initial begin
        errors      = 0;
        checks      = 0;
        timed_out   = 1'b0;
        lfsr_state  = 32'h46f5_3917;
        reset_n     = 1'b0;
        keygen_sign = 1'b0;
        en          = 1'b0;
        seed        = '0;
        priv_key    = '0;
        iv          = '0;
        hashed_msg  = '0;
        build_table();
        repeat (2) @(negedge clk);
        reset_n = 1'b1;
        @(negedge clk);
        check_word("reset", "ready", 32'd1, 32'(ready));
        check_word("reset", "lambda", '0, lambda);
        check_word("reset", "scalar_rnd", '0, scalar_rnd);
        check_word("reset", "masking_rnd", '0, masking_rnd);
        check_word("reset", "nonce", '0, nonce);
        for (int i = 0; i < num_tests && !timed_out; i++) begin
            run_entry(i);
        end
        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: ecc_drbg.f
+incdir+testbench
design/drbg_pkg.sv
design/drbg_mixer.sv
design/hmac_drbg.sv
design/ecc_hmac_drbg_interface.sv
design/ecc_drbg_top.sv
testbench/ecc_drbg_tb.sv

// File: Makefile
VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only --timing -Wall
TOP        := ecc_drbg_tb
RTL_TOP    := ecc_drbg_top
FILELIST   := ecc_drbg.f
BUILD_DIR  := obj_dir
PASS_MSG   := All tests passed!

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
